/* common/vdp_layer_pkg.sv */
/*
  Layer identities and priority widths for the compositing stage.
  Bits 0..3 of every mask are scroll layers 0..3 and bit 4 is sprites.
  A one-hot value of zero means no layer won, so the backdrop shows.
*/
`default_nettype none

package vdp_layer_pkg;

    localparam int num_scroll_layers = 4;
    localparam int layer_sprites = 4;
    localparam int num_layers = num_scroll_layers + 1;

    // sprite priority is compared against the scroll lane rank
    localparam int sprite_priority_width = 2;
    localparam int resolved_priority_width = sprite_priority_width + 1;

    typedef logic [num_layers-1:0] layer_mask_t;
    typedef logic [num_layers-1:0] layer_ohe_t;
    typedef logic [sprite_priority_width-1:0] sprite_priority_t;
    typedef logic [resolved_priority_width-1:0] resolved_priority_t;

    localparam layer_ohe_t layer_none_ohe = '0;
    localparam layer_ohe_t layer_sprites_ohe = layer_ohe_t'(1) << layer_sprites;

endpackage

`default_nettype wire

/* common/vdp_pixel_pkg.sv */
/*
  Pixel payloads and colour types.
  An index is {bank[3:0], colour[3:0]}; colour 0 of any bank is transparent.
  Output colours are RGB565.
*/
`default_nettype none

package vdp_pixel_pkg;

    import vdp_layer_pkg::*;

    localparam int palette_depth = 256;

    typedef logic [7:0] color_index_t;
    typedef logic [15:0] rgb565_t;

    typedef struct packed {
        color_index_t pixel;
    } scroll_payload_t;

    // prio stands in for the sprite priority, "priority" being a keyword
    typedef struct packed {
        sprite_priority_t prio;
        color_index_t pixel;
    } sprite_payload_t;

endpackage

`default_nettype wire

/* compositor/vdp_layer_priority_select.sv */
/*
  Picks the topmost opaque layer among four scroll layers and sprites.
  Scroll layer n scores 2*(3-n); sprites score 2*prio+1, so ties never occur.
  Winner, pixel and priority are combinational from this stage's registers.
  With nothing opaque the result is layer 0, priority 0 and index 0.
*/
`timescale 1ns/10ps
`default_nettype none

module vdp_layer_priority_select
    import vdp_layer_pkg::*;
    import vdp_pixel_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  layer_mask_t        opaque_mask,
    input  color_index_t       scroll_pixel [num_scroll_layers],
    input  sprite_priority_t   sprite_priority,
    input  color_index_t       sprite_pixel,
    output logic               out_valid,
    output layer_ohe_t         prioritized_layer,
    output color_index_t       prioritized_pixel,
    output resolved_priority_t resolved_priority
);

    color_index_t     scroll_pixel_r [num_scroll_layers];
    color_index_t     sprite_pixel_r;
    sprite_priority_t sprite_priority_r;
    layer_mask_t      opaque_mask_r;

    // scroll decision made while the inputs are registered
    sprite_priority_t scroll_rank;
    layer_ohe_t       scroll_ohe;

    resolved_priority_t scroll_score;
    resolved_priority_t sprite_score;

    always_ff @(posedge clk) begin
        scroll_pixel_r <= scroll_pixel;
        sprite_pixel_r <= sprite_pixel;
        sprite_priority_r <= sprite_priority;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            opaque_mask_r <= '0;
            scroll_rank <= '0;
            scroll_ohe <= layer_none_ohe;
        end else begin
            out_valid <= in_valid;
            opaque_mask_r <= opaque_mask;
            scroll_rank <= '0;
            scroll_ohe <= layer_none_ohe;
            // walk downwards so the lowest-numbered opaque lane is assigned last
            for (int n = num_scroll_layers - 1; n >= 0; n--) begin
                if (opaque_mask[n]) begin
                    scroll_rank <= sprite_priority_t'(num_scroll_layers - 1 - n);
                    scroll_ohe <= layer_ohe_t'(1) << n;
                end
            end
        end
    end

    assign scroll_score = {scroll_rank, 1'b0};
    assign sprite_score = {sprite_priority_r, 1'b1};

    always_comb begin
        if (opaque_mask_r[layer_sprites] && (sprite_score > scroll_score)) begin
            prioritized_layer = layer_sprites_ohe;
            resolved_priority = sprite_score;
        end else if (|opaque_mask_r[num_scroll_layers-1:0]) begin
            prioritized_layer = scroll_ohe;
            resolved_priority = scroll_score;
        end else begin
            prioritized_layer = layer_none_ohe;
            resolved_priority = '0;
        end
    end

    // one-hot winner, so the lanes never overlap; falls back to backdrop index 0
    always_comb begin
        prioritized_pixel = '0;
        if (prioritized_layer[layer_sprites]) begin
            prioritized_pixel = sprite_pixel_r;
        end
        for (int n = 0; n < num_scroll_layers; n++) begin
            if (prioritized_layer[n]) begin
                prioritized_pixel = scroll_pixel_r[n];
            end
        end
    end

endmodule

`default_nettype wire

/* flist.f */
common/vdp_layer_pkg.sv
common/vdp_pixel_pkg.sv
layer/vdp_layer_stage.sv
compositor/vdp_layer_priority_select.sv
logic/vdp_palette_lookup.sv
logic/vdp_compositor_top.sv
sim/tb_vdp_compositor.sv

/* layer/vdp_layer_stage.sv */
/*
  One registered layer stage, shared by the scroll and sprite payloads.
  payload_t must be a packed struct with a color_index_t field named pixel.
  enable is treated as static, so it is sampled with the payload.
*/
`timescale 1ns/10ps
`default_nettype none

module vdp_layer_stage
    import vdp_pixel_pkg::*;
#(
    parameter type payload_t = scroll_payload_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  logic     enable,
    input  payload_t payload,
    output logic     out_valid,
    output payload_t out_payload,
    output logic     opaque
);

    logic is_visible;

    // colour 0 within a bank is the transparent entry
    assign is_visible = enable && (payload.pixel[3:0] != 4'h0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            opaque <= 1'b0;
        end else begin
            out_valid <= in_valid;
            opaque <= is_visible;
        end
    end

    // payload is data only
    always_ff @(posedge clk) begin
        out_payload <= payload;
    end

endmodule

`default_nettype wire

/* logic/vdp_compositor_top.sv */
/*
  Compositing stage: layer registers, priority select, palette lookup.
  Fixed latency of 3 cycles from pixel_valid to color_valid, no stalls.
  layer_enable is static configuration and is not retimed with the pixels.
*/
`timescale 1ns/10ps
`default_nettype none

module vdp_compositor_top
    import vdp_layer_pkg::*;
    import vdp_pixel_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pixel_valid,
    input  scroll_payload_t    scroll_pixel [num_scroll_layers],
    input  sprite_payload_t    sprite_pixel,
    input  layer_mask_t        layer_enable,
    input  logic               palette_we,
    input  color_index_t       palette_addr,
    input  rgb565_t            palette_data,
    output logic               color_valid,
    output rgb565_t            color,
    output layer_ohe_t         out_layer,
    output resolved_priority_t out_priority
);

    scroll_payload_t               scroll_q [num_scroll_layers];
    color_index_t                  scroll_index [num_scroll_layers];
    logic [num_scroll_layers-1:0]  scroll_valid;
    sprite_payload_t               sprite_q;
    logic                          sprite_valid;
    layer_mask_t                   opaque_mask;
    logic                          stage_valid;

    logic               sel_valid;
    color_index_t       sel_index;
    layer_ohe_t         sel_layer;
    resolved_priority_t sel_priority;

    for (genvar i = 0; i < num_scroll_layers; i++) begin : g_scroll_lane
        vdp_layer_stage #(
            .payload_t(scroll_payload_t)
        ) u_scroll_stage (
            .clk        (clk),
            .rst_n      (rst_n),
            .in_valid   (pixel_valid),
            .enable     (layer_enable[i]),
            .payload    (scroll_pixel[i]),
            .out_valid  (scroll_valid[i]),
            .out_payload(scroll_q[i]),
            .opaque     (opaque_mask[i])
        );

        assign scroll_index[i] = scroll_q[i].pixel;
    end

    vdp_layer_stage #(
        .payload_t(sprite_payload_t)
    ) u_sprite_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (pixel_valid),
        .enable     (layer_enable[layer_sprites]),
        .payload    (sprite_pixel),
        .out_valid  (sprite_valid),
        .out_payload(sprite_q),
        .opaque     (opaque_mask[layer_sprites])
    );

    // all lanes share one strobe, so they agree every cycle
    assign stage_valid = (&scroll_valid) & sprite_valid;

    vdp_layer_priority_select u_select (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (stage_valid),
        .opaque_mask      (opaque_mask),
        .scroll_pixel     (scroll_index),
        .sprite_priority  (sprite_q.prio),
        .sprite_pixel     (sprite_q.pixel),
        .out_valid        (sel_valid),
        .prioritized_layer(sel_layer),
        .prioritized_pixel(sel_index),
        .resolved_priority(sel_priority)
    );

    vdp_palette_lookup u_palette (
        .clk         (clk),
        .rst_n       (rst_n),
        .we          (palette_we),
        .waddr       (palette_addr),
        .wdata       (palette_data),
        .in_valid    (sel_valid),
        .index       (sel_index),
        .in_layer    (sel_layer),
        .in_priority (sel_priority),
        .out_valid   (color_valid),
        .color       (color),
        .out_layer   (out_layer),
        .out_priority(out_priority)
    );

endmodule

`default_nettype wire

/* logic/vdp_palette_lookup.sv */
/*
  256 x RGB565 palette with a host write port and a registered read.
  A read of the address written in the same cycle returns the old entry.
  Memory contents are undefined until the host loads them.
*/
`timescale 1ns/10ps
`default_nettype none

module vdp_palette_lookup
    import vdp_layer_pkg::*;
    import vdp_pixel_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               we,
    input  color_index_t       waddr,
    input  rgb565_t            wdata,
    input  logic               in_valid,
    input  color_index_t       index,
    input  layer_ohe_t         in_layer,
    input  resolved_priority_t in_priority,
    output logic               out_valid,
    output rgb565_t            color,
    output layer_ohe_t         out_layer,
    output resolved_priority_t out_priority
);

    rgb565_t palette_mem [palette_depth];

    always_ff @(posedge clk) begin
        if (we) begin
            palette_mem[waddr] <= wdata;
        end
    end

    // layer and priority ride along so they line up with the colour
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            color <= '0;
            out_layer <= layer_none_ohe;
            out_priority <= '0;
        end else begin
            out_valid <= in_valid;
            color <= palette_mem[index];
            out_layer <= in_layer;
            out_priority <= in_priority;
        end
    end

endmodule

`default_nettype wire

/* sim/tb_vdp_compositor.sv */
/*
  Table-driven testbench for the compositing stage.
  Loads all 256 palette entries, then streams pixel rows back-to-back.
  Each row must come out exactly 3 cycles later; stops at the first error.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_vdp_compositor
    import vdp_layer_pkg::*;
    import vdp_pixel_pkg::*;
;

    typedef struct packed {
        layer_mask_t                                 enable;
        color_index_t [num_scroll_layers-1:0]        scroll;
        sprite_priority_t                            sprite_prio;
        color_index_t                                sprite_pixel;
        layer_ohe_t                                  exp_layer;
        resolved_priority_t                          exp_prio;
    } row_t;

    typedef struct packed {
        int unsigned        due;
        rgb565_t            color;
        layer_ohe_t         layer;
        resolved_priority_t prio;
    } expect_t;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               pixel_valid;
    scroll_payload_t    scroll_pixel [num_scroll_layers];
    sprite_payload_t    sprite_pixel;
    layer_mask_t        layer_enable;
    logic               palette_we;
    color_index_t       palette_addr;
    rgb565_t            palette_data;
    logic               color_valid;
    rgb565_t            color;
    layer_ohe_t         out_layer;
    resolved_priority_t out_priority;

    int          seed = 32'h536b30f7;
    int unsigned cycle_count = 0;
    int unsigned timeout_limit = 100000;
    rgb565_t     exp_palette [palette_depth];
    row_t        rows [$];
    expect_t     pending [$];

    vdp_compositor_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_valid (pixel_valid),
        .scroll_pixel(scroll_pixel),
        .sprite_pixel(sprite_pixel),
        .layer_enable(layer_enable),
        .palette_we  (palette_we),
        .palette_addr(palette_addr),
        .palette_data(palette_data),
        .color_valid (color_valid),
        .color       (color),
        .out_layer   (out_layer),
        .out_priority(out_priority)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            stop_on_error();
        end
    end

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_color(input rgb565_t got, input rgb565_t exp);
        if (got !== exp) begin
            $display("error at %0d ns: color is %h, expected %h", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_layer(input layer_ohe_t got, input layer_ohe_t exp);
        if (got !== exp) begin
            $display("error at %0d ns: out_layer is %b, expected %b", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_priority(input resolved_priority_t got, input resolved_priority_t exp);
        if (got !== exp) begin
            $display("error at %0d ns: out_priority is %0d, expected %0d", $time, got, exp);
            stop_on_error();
        end
    endtask

    function automatic row_t make_row(input layer_mask_t en, input color_index_t s0,
                                      input color_index_t s1, input color_index_t s2,
                                      input color_index_t s3, input sprite_priority_t sp,
                                      input color_index_t si, input layer_ohe_t layer,
                                      input resolved_priority_t prio);
        row_t r;
        r.enable = en;
        r.scroll = {s3, s2, s1, s0};
        r.sprite_prio = sp;
        r.sprite_pixel = si;
        r.exp_layer = layer;
        r.exp_prio = prio;
        return r;
    endfunction

    // index of the expected winner; backdrop uses entry 0
    function automatic color_index_t winner_index(input row_t r);
        if (r.exp_layer[layer_sprites]) begin
            return r.sprite_pixel;
        end
        for (int n = 0; n < num_scroll_layers; n++) begin
            if (r.exp_layer[n]) begin
                return r.scroll[n];
            end
        end
        return '0;
    endfunction

    task automatic build_rows();
        row_t r;
        int   lane;
        // scroll ordering, sprite disabled
        rows.push_back(make_row(5'h0f, 8'h11, 8'h22, 8'h33, 8'h44, 2'd3, 8'h5a, 5'h01, 3'd6));
        rows.push_back(make_row(5'h0f, 8'h10, 8'h22, 8'h33, 8'h44, 2'd3, 8'h5a, 5'h02, 3'd4));
        rows.push_back(make_row(5'h0f, 8'h20, 8'h30, 8'h35, 8'h44, 2'd3, 8'h5a, 5'h04, 3'd2));
        rows.push_back(make_row(5'h0f, 8'h00, 8'h10, 8'h20, 8'h4f, 2'd3, 8'h5a, 5'h08, 3'd0));
        // sprite against each scroll lane, odd against even scores
        rows.push_back(make_row(5'h1f, 8'h11, 8'h22, 8'h33, 8'h44, 2'd3, 8'h5a, 5'h10, 3'd7));
        rows.push_back(make_row(5'h1f, 8'h11, 8'h22, 8'h33, 8'h44, 2'd2, 8'h5a, 5'h01, 3'd6));
        rows.push_back(make_row(5'h1f, 8'h10, 8'h22, 8'h33, 8'h44, 2'd2, 8'h6b, 5'h10, 3'd5));
        rows.push_back(make_row(5'h1f, 8'h10, 8'h22, 8'h33, 8'h44, 2'd1, 8'h6b, 5'h02, 3'd4));
        rows.push_back(make_row(5'h1f, 8'h10, 8'h20, 8'h3c, 8'h44, 2'd1, 8'h7c, 5'h10, 3'd3));
        rows.push_back(make_row(5'h1f, 8'h10, 8'h20, 8'h3c, 8'h44, 2'd0, 8'h7c, 5'h04, 3'd2));
        rows.push_back(make_row(5'h1f, 8'h10, 8'h20, 8'h30, 8'h4c, 2'd0, 8'h8d, 5'h10, 3'd1));
        rows.push_back(make_row(5'h1f, 8'h00, 8'h90, 8'ha0, 8'hb0, 2'd0, 8'h9e, 5'h10, 3'd1));
        rows.push_back(make_row(5'h1f, 8'h00, 8'h90, 8'ha0, 8'hb0, 2'd3, 8'hff, 5'h10, 3'd7));
        // transparency and enables fall through
        rows.push_back(make_row(5'h1e, 8'h11, 8'h22, 8'h33, 8'h44, 2'd0, 8'h5a, 5'h02, 3'd4));
        rows.push_back(make_row(5'h1c, 8'h11, 8'h22, 8'h3c, 8'h44, 2'd0, 8'h5a, 5'h04, 3'd2));
        rows.push_back(make_row(5'h0f, 8'hc1, 8'h22, 8'h33, 8'h44, 2'd3, 8'h5a, 5'h01, 3'd6));
        rows.push_back(make_row(5'h1f, 8'hd2, 8'h22, 8'h33, 8'h44, 2'd3, 8'h50, 5'h01, 3'd6));
        // backdrop
        rows.push_back(make_row(5'h10, 8'h11, 8'h22, 8'h33, 8'h44, 2'd3, 8'h50, 5'h00, 3'd0));
        rows.push_back(make_row(5'h1f, 8'h00, 8'h10, 8'h20, 8'h30, 2'd2, 8'hf0, 5'h00, 3'd0));
        rows.push_back(make_row(5'h00, 8'h11, 8'h22, 8'h33, 8'h44, 2'd3, 8'h5a, 5'h00, 3'd0));
        // sweep every selectable palette entry, rotating the winning layer
        for (int i = 1; i < palette_depth; i++) begin
            if (i[3:0] != 4'h0) begin
                lane = i % num_layers;
                for (int n = 0; n < num_scroll_layers; n++) begin
                    r.scroll[n] = color_index_t'($random(seed));
                end
                r.sprite_prio = sprite_priority_t'($random(seed));
                r.sprite_pixel = color_index_t'($random(seed));
                r.enable = layer_mask_t'(1) << lane;
                r.exp_layer = layer_ohe_t'(1) << lane;
                if (lane < num_scroll_layers) begin
                    r.scroll[lane] = color_index_t'(i);
                    r.exp_prio = resolved_priority_t'(2 * (3 - lane));
                end else begin
                    r.sprite_pixel = color_index_t'(i);
                    r.exp_prio = resolved_priority_t'(2 * r.sprite_prio + 1);
                end
                rows.push_back(r);
            end
        end
    endtask

    task automatic apply_row(input row_t r);
        expect_t e;
        pixel_valid = 1'b1;
        layer_enable = r.enable;
        for (int n = 0; n < num_scroll_layers; n++) begin
            scroll_pixel[n].pixel = r.scroll[n];
        end
        sprite_pixel.prio = r.sprite_prio;
        sprite_pixel.pixel = r.sprite_pixel;
        e.due = cycle_count + 3;
        e.color = exp_palette[winner_index(r)];
        e.layer = r.exp_layer;
        e.prio = r.exp_prio;
        pending.push_back(e);
        @(posedge clk);
        #1;
    endtask

    // outputs are sampled mid-cycle, well away from the driving edge
    always @(negedge clk) begin : check_outputs
        expect_t head;
        if (pending.size() != 0 && pending[0].due == cycle_count) begin
            head = pending.pop_front();
            if (color_valid !== 1'b1) begin
                $display("color_valid stayed low when a pixel was due at %0d ns", $time);
                stop_on_error();
            end
            check_color(color, head.color);
            check_layer(out_layer, head.layer);
            check_priority(out_priority, head.prio);
        end else if (rst_n && color_valid !== 1'b0) begin
            $display("color_valid was high with no pixel due at %0d ns", $time);
            stop_on_error();
        end
    end

    initial begin
        rst_n = 1'b0;
        pixel_valid = 1'b0;
        layer_enable = '0;
        for (int n = 0; n < num_scroll_layers; n++) begin
            scroll_pixel[n] = '0;
        end
        sprite_pixel = '0;
        palette_we = 1'b0;
        palette_addr = '0;
        palette_data = '0;
        for (int i = 0; i < palette_depth; i++) begin
            exp_palette[i] = rgb565_t'($random(seed));
        end
        build_rows();
        timeout_limit = 2 + palette_depth + rows.size() + 20;

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // host loads the whole palette, one entry per cycle
        for (int i = 0; i < palette_depth; i++) begin
            palette_we = 1'b1;
            palette_addr = color_index_t'(i);
            palette_data = exp_palette[i];
            @(posedge clk);
            #1;
        end
        palette_we = 1'b0;

        foreach (rows[k]) begin
            apply_row(rows[k]);
        end
        pixel_valid = 1'b0;

        while (pending.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire
